// ==== dds_pkg.sv ====
`default_nettype none

package dds_pkg;

  localparam int AMP_W    = 9;   // 256 is unity gain
  localparam int FREQ_W   = 32;
  localparam int PHASE_W  = 12;
  localparam int SAMPLE_W = 8;

  localparam logic [SAMPLE_W-1:0] MID_CODE = 8'd128;

  typedef enum logic [1:0] {
    WAVE_SINE,
    WAVE_SQUARE,
    WAVE_TRIANGLE,
    WAVE_SAW
  } wave_e;

  typedef enum logic [7:0] {
    CMD_WAVE  = 8'd1,
    CMD_AMP   = 8'd2,
    CMD_FREQ  = 8'd3,
    CMD_PHASE = 8'd4
  } cmd_op_e;

  // raw 8-bit sample from a 10-bit phase index
  function automatic logic [SAMPLE_W-1:0] wave_sample(input logic [9:0] idx,
                                                     input wave_e wave);
    logic [8:0]          x;
    logic [17:0]         prod;
    logic [9:0]          y;
    int                  sine_v;
    logic [SAMPLE_W-1:0] res;
    x    = idx[8:0];
    prod = x * (9'd511 - x);  // parabola peaking near x = 256
    y    = prod[17:8];
    if (!idx[9]) begin
      sine_v = 128 + int'(y[9:1]);
    end else begin
      sine_v = 128 - int'(y[9:1]);
    end
    if (sine_v < 0) sine_v = 0;
    if (sine_v > 255) sine_v = 255;
    case (wave)
      WAVE_SINE:     res = sine_v[7:0];
      WAVE_SQUARE:   res = idx[9] ? 8'd0 : 8'd255;
      WAVE_TRIANGLE: res = idx[9] ? (8'd255 - idx[8:1]) : idx[8:1];
      default:       res = idx[9:2];  // saw
    endcase
    return res;
  endfunction

  // saturating gain around midscale with 8 fractional bits
  function automatic logic [SAMPLE_W-1:0] scale_sample(input logic [SAMPLE_W-1:0] raw,
                                                      input logic [AMP_W-1:0] amp);
    logic signed [9:0]  diff;
    logic signed [19:0] prod;
    logic signed [19:0] sum;
    diff = $signed({2'b00, raw}) - $signed({2'b00, MID_CODE});
    prod = diff * $signed({1'b0, amp});
    sum  = (prod >>> 8) + 20'sd128;
    if (sum < 20'sd0) return 8'd0;
    if (sum > 20'sd255) return 8'd255;
    return sum[7:0];
  endfunction

endpackage

`default_nettype wire

// ==== dds_cmd_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module dds_cmd_regs (
  input  wire                          sys_clk,
  input  wire                          rst_n,
  input  wire                          rec_en,        // rec_data valid
  input  wire  [31:0]                  rec_data,
  input  wire                          rec_pkt_done,  // one pulse after last word
  input  wire  [15:0]                  rec_byte_num,  // valid with rec_pkt_done
  output dds_pkg::wave_e               wave_select,
  output logic [dds_pkg::AMP_W-1:0]    amp_ctl,
  output logic [dds_pkg::FREQ_W-1:0]   freq_ctl,
  output logic [dds_pkg::PHASE_W-1:0]  phase_ctl,
  output logic                         cfg_load       // pulse on commit
);

  typedef enum logic {
    ST_HDR,
    ST_VAL
  } word_st_e;

  word_st_e                     state;
  dds_pkg::cmd_op_e             op_q;       // opcode of current pair
  dds_pkg::wave_e               wave_sh;
  logic [dds_pkg::AMP_W-1:0]    amp_sh;
  logic [dds_pkg::FREQ_W-1:0]   freq_sh;
  logic [dds_pkg::PHASE_W-1:0]  phase_sh;
  logic                         len_ok;

  // whole command pairs only
  assign len_ok = (rec_byte_num != 16'd0) && (rec_byte_num[2:0] == 3'd0);

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_HDR;
      op_q  <= dds_pkg::CMD_WAVE;
    end else if (rec_pkt_done) begin
      state <= ST_HDR;  // realign on every packet
    end else if (rec_en) begin
      if (state == ST_HDR) begin
        op_q  <= dds_pkg::cmd_op_e'(rec_data[31:24]);
        state <= ST_VAL;
      end else begin
        state <= ST_HDR;
      end
    end
  end

  // shadow copies staged until packet end
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      wave_sh  <= dds_pkg::WAVE_SINE;
      amp_sh   <= 9'd256;
      freq_sh  <= '0;
      phase_sh <= '0;
    end else if (rec_pkt_done) begin
      if (!len_ok) begin  // bad length restores the live values
        wave_sh  <= wave_select;
        amp_sh   <= amp_ctl;
        freq_sh  <= freq_ctl;
        phase_sh <= phase_ctl;
      end
    end else if (rec_en && state == ST_VAL) begin
      case (op_q)
        dds_pkg::CMD_WAVE:  wave_sh  <= dds_pkg::wave_e'(rec_data[1:0]);
        dds_pkg::CMD_AMP:   amp_sh   <= rec_data[8:0];
        dds_pkg::CMD_FREQ:  freq_sh  <= rec_data[31:0];
        dds_pkg::CMD_PHASE: phase_sh <= rec_data[11:0];
        default: ;  // unknown opcode
      endcase
    end
  end

  // live registers
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      wave_select <= dds_pkg::WAVE_SINE;
      amp_ctl     <= 9'd256;
      freq_ctl    <= '0;
      phase_ctl   <= '0;
      cfg_load    <= 1'b0;
    end else begin
      cfg_load <= 1'b0;
      if (rec_pkt_done && len_ok) begin
        wave_select <= wave_sh;
        amp_ctl     <= amp_sh;
        freq_ctl    <= freq_sh;
        phase_ctl   <= phase_sh;
        cfg_load    <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dds_phase_acc.sv ====
`timescale 1ns/1ps
`default_nettype none

module dds_phase_acc #(
  parameter int ACC_W = 32  // at least PHASE_W
) (
  input  wire                          sys_clk,
  input  wire                          rst_n,
  input  wire  [dds_pkg::FREQ_W-1:0]   freq_ctl,   // tuning word
  input  wire  [dds_pkg::PHASE_W-1:0]  phase_ctl,  // phase offset
  input  wire                          cfg_load,   // resync
  output logic [dds_pkg::PHASE_W-1:0]  phase_idx
);

  logic [ACC_W-1:0] acc;
  logic [ACC_W-1:0] step;

  assign step = ACC_W'(freq_ctl);

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      acc       <= '0;
      phase_idx <= '0;
    end else begin
      if (cfg_load) begin
        acc <= '0;  // restart from phase zero
      end else begin
        acc <= acc + step;
      end
      // offset wraps modulo 4096
      phase_idx <= acc[ACC_W-1 -: dds_pkg::PHASE_W] + phase_ctl;
    end
  end

endmodule

`default_nettype wire

// ==== dds_wave_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module dds_wave_gen (
  input  wire                           sys_clk,
  input  wire                           rst_n,
  input  wire   [dds_pkg::PHASE_W-1:0]  phase_idx,
  input  wire   dds_pkg::wave_e         wave_select,
  input  wire   [dds_pkg::AMP_W-1:0]    amp_ctl,
  output logic  [dds_pkg::SAMPLE_W-1:0] da_data      // DAC word
);

  logic [9:0]                   tbl_idx;
  logic [dds_pkg::SAMPLE_W-1:0] raw_sample;
  logic [dds_pkg::SAMPLE_W-1:0] dac_next;

  assign tbl_idx = phase_idx[dds_pkg::PHASE_W-1 -: 10];  // drop low bits

  always_comb begin
    raw_sample = dds_pkg::wave_sample(tbl_idx, wave_select);
    dac_next   = dds_pkg::scale_sample(raw_sample, amp_ctl);  // gain and clip
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      da_data <= dds_pkg::MID_CODE;  // idle at midscale
    end else begin
      da_data <= dac_next;
    end
  end

endmodule

`default_nettype wire

// ==== adc_measure.sv ====
`timescale 1ns/1ps
`default_nettype none

module adc_measure #(
  parameter int WIN_LEN = 16  // samples per window
) (
  input  wire                           sys_clk,
  input  wire                           rst_n,
  input  wire   [dds_pkg::SAMPLE_W-1:0] ad_data,
  output logic  [dds_pkg::SAMPLE_W-1:0] ad_max,
  output logic  [dds_pkg::SAMPLE_W-1:0] ad_min,
  output logic  [dds_pkg::SAMPLE_W-1:0] ad_vpp,
  output logic                          meas_done
);

  localparam int CNT_W = (WIN_LEN > 1) ? $clog2(WIN_LEN) : 1;

  logic [CNT_W-1:0]             win_cnt;
  logic                         win_first;
  logic                         win_last;
  logic [dds_pkg::SAMPLE_W-1:0] run_max;
  logic [dds_pkg::SAMPLE_W-1:0] run_min;
  logic [dds_pkg::SAMPLE_W-1:0] nxt_max;
  logic [dds_pkg::SAMPLE_W-1:0] nxt_min;

  assign win_first = (win_cnt == '0);
  assign win_last  = (win_cnt == CNT_W'(WIN_LEN - 1));

  // first sample of a window seeds both extremes
  assign nxt_max = (win_first || ad_data > run_max) ? ad_data : run_max;
  assign nxt_min = (win_first || ad_data < run_min) ? ad_data : run_min;

  always_ff @(posedge sys_clk) begin
    run_max <= nxt_max;
    run_min <= nxt_min;
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      win_cnt   <= '0;
      ad_max    <= '0;
      ad_min    <= '0;
      ad_vpp    <= '0;
      meas_done <= 1'b0;
    end else begin
      meas_done <= 1'b0;
      if (win_last) begin
        win_cnt   <= '0;
        ad_max    <= nxt_max;
        ad_min    <= nxt_min;
        ad_vpp    <= nxt_max - nxt_min;  // never negative
        meas_done <= 1'b1;
      end else begin
        win_cnt <= win_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dds_dso_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dds_dso_top #(
  parameter int ACC_W   = 32,  // phase accumulator width
  parameter int WIN_LEN = 16   // measurement window
) (
  input  wire                          sys_clk,
  input  wire                          rst_n,
  input  wire                          rec_en,        // from UDP receiver
  input  wire  [31:0]                  rec_data,
  input  wire                          rec_pkt_done,
  input  wire  [15:0]                  rec_byte_num,
  input  wire  [dds_pkg::SAMPLE_W-1:0] ad_data,       // ADC samples
  output wire  [dds_pkg::SAMPLE_W-1:0] da_data,       // DAC word
  output wire  [dds_pkg::SAMPLE_W-1:0] ad_max,
  output wire  [dds_pkg::SAMPLE_W-1:0] ad_min,
  output wire  [dds_pkg::SAMPLE_W-1:0] ad_vpp,
  output wire                          meas_done
);

  wire dds_pkg::wave_e               wave_select;
  wire [dds_pkg::AMP_W-1:0]          amp_ctl;
  wire [dds_pkg::FREQ_W-1:0]         freq_ctl;
  wire [dds_pkg::PHASE_W-1:0]        phase_ctl;
  wire                               cfg_load;
  wire [dds_pkg::PHASE_W-1:0]        phase_idx;

  dds_cmd_regs u_dds_cmd_regs (
    .sys_clk      (sys_clk),
    .rst_n        (rst_n),
    .rec_en       (rec_en),
    .rec_data     (rec_data),
    .rec_pkt_done (rec_pkt_done),
    .rec_byte_num (rec_byte_num),
    .wave_select  (wave_select),
    .amp_ctl      (amp_ctl),
    .freq_ctl     (freq_ctl),
    .phase_ctl    (phase_ctl),
    .cfg_load     (cfg_load)
  );

  dds_phase_acc #(
    .ACC_W (ACC_W)
  ) u_dds_phase_acc (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .freq_ctl  (freq_ctl),
    .phase_ctl (phase_ctl),
    .cfg_load  (cfg_load),   // resync on commit
    .phase_idx (phase_idx)
  );

  dds_wave_gen u_dds_wave_gen (
    .sys_clk     (sys_clk),
    .rst_n       (rst_n),
    .phase_idx   (phase_idx),
    .wave_select (wave_select),
    .amp_ctl     (amp_ctl),
    .da_data     (da_data)
  );

  adc_measure #(
    .WIN_LEN (WIN_LEN)
  ) u_adc_measure (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .ad_data   (ad_data),
    .ad_max    (ad_max),
    .ad_min    (ad_min),
    .ad_vpp    (ad_vpp),
    .meas_done (meas_done)
  );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_NS = 5  // 10 ns period
) (
  output logic clk
);

  initial clk = 1'b0;

  always #HALF_NS clk = ~clk;

endmodule

`default_nettype wire

// ==== dds_dso_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module dds_dso_props (
  input wire                         sys_clk,
  input wire                         rst_n,
  input wire                         cfg_load,
  input wire                         meas_done,
  input wire [dds_pkg::SAMPLE_W-1:0] ad_max,
  input wire [dds_pkg::SAMPLE_W-1:0] ad_min,
  input wire [dds_pkg::SAMPLE_W-1:0] ad_vpp
);

  a_cfg_load_pulse: assert property (@(posedge sys_clk) disable iff (!rst_n)
    cfg_load |=> !cfg_load)
    else $error("cfg_load high for two cycles");

  a_meas_done_pulse: assert property (@(posedge sys_clk) disable iff (!rst_n)
    meas_done |=> !meas_done)
    else $error("meas_done high for two cycles");

  // published results are consistent
  a_vpp_diff: assert property (@(posedge sys_clk) disable iff (!rst_n)
    meas_done |-> (ad_vpp == ad_max - ad_min))
    else $error("ad_vpp is not ad_max minus ad_min");

  a_max_ge_min: assert property (@(posedge sys_clk) disable iff (!rst_n)
    ad_max >= ad_min)
    else $error("ad_max below ad_min");

endmodule

bind dds_dso_top dds_dso_props u_props (
  .sys_clk   (sys_clk),
  .rst_n     (rst_n),
  .cfg_load  (cfg_load),
  .meas_done (meas_done),
  .ad_max    (ad_max),
  .ad_min    (ad_min),
  .ad_vpp    (ad_vpp)
);

`default_nettype wire

// ==== tb_dds_dso_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dds_dso_top;

  localparam int ACC_W     = 32;
  localparam int WIN_LEN   = 16;
  localparam int N_ENTRY   = 20;
  localparam int SWEEP_LEN = 40;  // samples checked after a nonzero freq commit

  typedef struct packed {
    logic [1:0]     n_cmd;      // command pairs in the packet
    logic [7:0]     op0;
    logic [31:0]    val0;
    logic [7:0]     op1;
    logic [31:0]    val1;
    logic [7:0]     op2;
    logic [31:0]    val2;
    logic [15:0]    byte_num;
    dds_pkg::wave_e exp_wave;   // live settings after the packet
    logic [8:0]     exp_amp;
    logic [31:0]    exp_freq;
    logic [11:0]    exp_phase;
    logic           exp_load;
    logic [7:0]     ad_lo;      // ADC sample range
    logic [7:0]     ad_hi;
    logic [1:0]     n_win;
  } entry_t;

  wire         sys_clk;
  logic        rst_n;
  logic        rec_en;
  logic [31:0] rec_data;
  logic        rec_pkt_done;
  logic [15:0] rec_byte_num;
  logic [7:0]  ad_data;
  wire  [7:0]  da_data;
  wire  [7:0]  ad_max;
  wire  [7:0]  ad_min;
  wire  [7:0]  ad_vpp;
  wire         meas_done;

  entry_t tbl [N_ENTRY];
  integer seed = 32'hb0;
  int     n_checks;
  int     n_errors;

  tb_clk_gen u_clk_gen (.clk(sys_clk));

  dds_dso_top #(
    .ACC_W   (ACC_W),
    .WIN_LEN (WIN_LEN)
  ) uut (
    .sys_clk      (sys_clk),
    .rst_n        (rst_n),
    .rec_en       (rec_en),
    .rec_data     (rec_data),
    .rec_pkt_done (rec_pkt_done),
    .rec_byte_num (rec_byte_num),
    .ad_data      (ad_data),
    .da_data      (da_data),
    .ad_max       (ad_max),
    .ad_min       (ad_min),
    .ad_vpp       (ad_vpp),
    .meas_done    (meas_done)
  );

  function automatic int clip_byte(int v);
    if (v < 0) return 0;
    if (v > 255) return 255;
    return v;
  endfunction

  // raw sample from a 10-bit index
  function automatic int wave_model(int idx, dds_pkg::wave_e w);
    int h;
    int x;
    int y;
    h = (idx >> 9) & 1;
    x = idx & 511;
    case (w)
      dds_pkg::WAVE_SINE: begin
        y = (x * (511 - x)) >> 8;
        return clip_byte(h ? 128 - y / 2 : 128 + y / 2);
      end
      dds_pkg::WAVE_SQUARE:   return h ? 0 : 255;
      dds_pkg::WAVE_TRIANGLE: return h ? 255 - ((idx >> 1) & 255) : (idx >> 1) & 255;
      default:                return (idx >> 2) & 255;
    endcase
  endfunction

  function automatic int gain_model(int raw, int amp);
    return clip_byte(128 + (((raw - 128) * amp) >>> 8));
  endfunction

  // DAC word for the k-th accumulator step after a resync
  function automatic logic [7:0] expected_da(entry_t e, int k);
    logic [31:0] acc;
    int          idx12;
    acc   = e.exp_freq * 32'(k);
    idx12 = (int'(acc[31:20]) + int'(e.exp_phase)) % 4096;
    return 8'(gain_model(wave_model(idx12 >> 2, e.exp_wave), int'(e.exp_amp)));
  endfunction

  task automatic check_wave(string sig, dds_pkg::wave_e got, dds_pkg::wave_e exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %s: expected %h, got %h at %0t", sig, exp, got, $time);
    end
  endtask

  task automatic check_sample(string sig, logic [7:0] got, logic [7:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %s: expected %h, got %h at %0t", sig, exp, got, $time);
    end
  endtask

  task automatic check_flag(string sig, logic got, logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %s: expected %h, got %h at %0t", sig, exp, got, $time);
    end
  endtask

  task automatic send_word(logic [31:0] w);
    rec_en   = 1'b1;
    rec_data = w;
    @(posedge sys_clk);
    #1;
    rec_en   = 1'b0;
  endtask

  // returns 1 ns after the edge that samples rec_pkt_done
  task automatic send_packet(entry_t e);
    if (e.n_cmd > 0) begin
      send_word({e.op0, 24'h0});
      send_word(e.val0);
    end
    if (e.n_cmd > 1) begin
      send_word({e.op1, 24'h0});
      send_word(e.val1);
    end
    if (e.n_cmd > 2) begin
      send_word({e.op2, 24'h0});
      send_word(e.val2);
    end
    rec_pkt_done = 1'b1;
    rec_byte_num = e.byte_num;
    @(posedge sys_clk);
    #1;
    rec_pkt_done = 1'b0;
  endtask

  task automatic check_dac(entry_t e);
    int n_samp;
    for (int c = 0; c < 3; c++) begin
      if (!e.exp_load) check_sample("da_data", da_data, expected_da(e, 0));  // must hold
      @(posedge sys_clk);
      #1;
    end
    n_samp = (e.exp_freq != 0) ? SWEEP_LEN : 4;
    for (int k = 0; k < n_samp; k++) begin
      check_sample("da_data", da_data, expected_da(e, k));
      @(posedge sys_clk);
      #1;
    end
  endtask

  task automatic wait_meas_done();
    int cnt;
    cnt = 0;
    while (meas_done !== 1'b1 && cnt < 2 * WIN_LEN + 4) begin
      @(posedge sys_clk);
      #1;
      cnt++;
    end
    if (meas_done !== 1'b1) begin
      n_errors++;
      $display("meas_done never came within %0d cycles at %0t", cnt, $time);
    end
  endtask

  task automatic measure_windows(entry_t e);
    logic [31:0] r;
    int          span;
    int          smp;
    int          lo_s;
    int          hi_s;
    span = int'(e.ad_hi) - int'(e.ad_lo) + 1;
    wait_meas_done();  // align to window start
    for (int w = 0; w < int'(e.n_win); w++) begin
      lo_s = 255;
      hi_s = 0;
      for (int i = 0; i < WIN_LEN; i++) begin
        r   = $random(seed);
        smp = int'(e.ad_lo) + int'(r[30:0]) % span;
        if (smp > hi_s) hi_s = smp;
        if (smp < lo_s) lo_s = smp;
        ad_data = 8'(smp);
        @(posedge sys_clk);
        #1;
      end
      wait_meas_done();
      check_sample("ad_max", ad_max, 8'(hi_s));
      check_sample("ad_min", ad_min, 8'(lo_s));
      check_sample("ad_vpp", ad_vpp, 8'(hi_s - lo_s));
    end
  endtask

  task automatic fill_table();
    // n, op0, val0, op1, val1, op2, val2, bytes; wave, amp, freq, phase, load; lo, hi, windows
    tbl[0]  = '{2'd3, dds_pkg::CMD_WAVE, 32'd1, dds_pkg::CMD_AMP, 32'd256,
                dds_pkg::CMD_PHASE, 32'h000, 16'd24,
                dds_pkg::WAVE_SQUARE, 9'd256, 32'd0, 12'h000, 1'b1, 8'd0, 8'd255, 2'd1};
    tbl[1]  = '{2'd1, dds_pkg::CMD_PHASE, 32'h800, 8'd0, 32'd0, 8'd0, 32'd0, 16'd8,
                dds_pkg::WAVE_SQUARE, 9'd256, 32'd0, 12'h800, 1'b1, 8'd0, 8'd255, 2'd1};
    tbl[2]  = '{2'd2, dds_pkg::CMD_WAVE, 32'd0, dds_pkg::CMD_PHASE, 32'h400, 8'd0, 32'd0, 16'd16,
                dds_pkg::WAVE_SINE, 9'd256, 32'd0, 12'h400, 1'b1, 8'd100, 8'd150, 2'd1};
    tbl[3]  = '{2'd1, dds_pkg::CMD_PHASE, 32'hc00, 8'd0, 32'd0, 8'd0, 32'd0, 16'd8,
                dds_pkg::WAVE_SINE, 9'd256, 32'd0, 12'hc00, 1'b1, 8'd0, 8'd255, 2'd1};
    tbl[4]  = '{2'd2, dds_pkg::CMD_WAVE, 32'd2, dds_pkg::CMD_PHASE, 32'h300, 8'd0, 32'd0, 16'd16,
                dds_pkg::WAVE_TRIANGLE, 9'd256, 32'd0, 12'h300, 1'b1, 8'd0, 8'd255, 2'd1};
    tbl[5]  = '{2'd1, dds_pkg::CMD_PHASE, 32'ha00, 8'd0, 32'd0, 8'd0, 32'd0, 16'd8,
                dds_pkg::WAVE_TRIANGLE, 9'd256, 32'd0, 12'ha00, 1'b1, 8'd0, 8'd15, 2'd1};
    tbl[6]  = '{2'd2, dds_pkg::CMD_WAVE, 32'd3, dds_pkg::CMD_PHASE, 32'h5a0, 8'd0, 32'd0, 16'd16,
                dds_pkg::WAVE_SAW, 9'd256, 32'd0, 12'h5a0, 1'b1, 8'd0, 8'd255, 2'd1};
    tbl[7]  = '{2'd3, dds_pkg::CMD_WAVE, 32'd1, dds_pkg::CMD_AMP, 32'd0,
                dds_pkg::CMD_PHASE, 32'h000, 16'd24,
                dds_pkg::WAVE_SQUARE, 9'd0, 32'd0, 12'h000, 1'b1, 8'd0, 8'd255, 2'd1};
    tbl[8]  = '{2'd1, dds_pkg::CMD_AMP, 32'd128, 8'd0, 32'd0, 8'd0, 32'd0, 16'd8,
                dds_pkg::WAVE_SQUARE, 9'd128, 32'd0, 12'h000, 1'b1, 8'd240, 8'd255, 2'd1};
    tbl[9]  = '{2'd1, dds_pkg::CMD_AMP, 32'd511, 8'd0, 32'd0, 8'd0, 32'd0, 16'd8,
                dds_pkg::WAVE_SQUARE, 9'd511, 32'd0, 12'h000, 1'b1, 8'd0, 8'd255, 2'd1};
    tbl[10] = '{2'd1, dds_pkg::CMD_PHASE, 32'h800, 8'd0, 32'd0, 8'd0, 32'd0, 16'd8,
                dds_pkg::WAVE_SQUARE, 9'd511, 32'd0, 12'h800, 1'b1, 8'd0, 8'd255, 2'd1};
    tbl[11] = '{2'd3, dds_pkg::CMD_WAVE, 32'd3, dds_pkg::CMD_AMP, 32'd128,
                dds_pkg::CMD_PHASE, 32'h400, 16'd24,
                dds_pkg::WAVE_SAW, 9'd128, 32'd0, 12'h400, 1'b1, 8'd0, 8'd255, 2'd1};
    tbl[12] = '{2'd2, dds_pkg::CMD_WAVE, 32'd2, dds_pkg::CMD_AMP, 32'd256, 8'd0, 32'd0, 16'd12,
                dds_pkg::WAVE_SAW, 9'd128, 32'd0, 12'h400, 1'b0, 8'd0, 8'd255, 2'd1};
    tbl[13] = '{2'd1, dds_pkg::CMD_FREQ, 32'h1000_0000, 8'd0, 32'd0, 8'd0, 32'd0, 16'd0,
                dds_pkg::WAVE_SAW, 9'd128, 32'd0, 12'h400, 1'b0, 8'd0, 8'd255, 2'd1};
    tbl[14] = '{2'd3, dds_pkg::CMD_WAVE, 32'd0, 8'h7e, 32'h4000_0042,
                dds_pkg::CMD_AMP, 32'd256, 16'd24,
                dds_pkg::WAVE_SINE, 9'd256, 32'd0, 12'h400, 1'b1, 8'd0, 8'd255, 2'd1};
    tbl[15] = '{2'd3, dds_pkg::CMD_WAVE, 32'd3, dds_pkg::CMD_FREQ, 32'h0040_0000,
                dds_pkg::CMD_PHASE, 32'h000, 16'd24,
                dds_pkg::WAVE_SAW, 9'd256, 32'h0040_0000, 12'h000, 1'b1, 8'd0, 8'd255, 2'd1};
    tbl[16] = '{2'd3, dds_pkg::CMD_FREQ, 32'd0, dds_pkg::CMD_WAVE, 32'd2,
                dds_pkg::CMD_PHASE, 32'h6c0, 16'd24,
                dds_pkg::WAVE_TRIANGLE, 9'd256, 32'd0, 12'h6c0, 1'b1, 8'd77, 8'd77, 2'd2};
    tbl[17] = '{2'd0, 8'd0, 32'd0, 8'd0, 32'd0, 8'd0, 32'd0, 16'd0,
                dds_pkg::WAVE_TRIANGLE, 9'd256, 32'd0, 12'h6c0, 1'b0, 8'd200, 8'd255, 2'd2};
    tbl[18] = '{2'd3, dds_pkg::CMD_WAVE, 32'd3, dds_pkg::CMD_AMP, 32'd511,
                dds_pkg::CMD_PHASE, 32'hff0, 16'd24,
                dds_pkg::WAVE_SAW, 9'd511, 32'd0, 12'hff0, 1'b1, 8'd0, 8'd255, 2'd1};
    tbl[19] = '{2'd2, dds_pkg::CMD_AMP, 32'd0, dds_pkg::CMD_PHASE, 32'h000, 8'd0, 32'd0, 16'd16,
                dds_pkg::WAVE_SAW, 9'd0, 32'd0, 12'h000, 1'b1, 8'd0, 8'd255, 2'd1};
  endtask

  // watchdog allows 200 cycles per table entry
  initial begin
    repeat (N_ENTRY * 200 + 100) @(posedge sys_clk);
    $display("watchdog expired before the table was finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    rst_n        = 1'b0;
    rec_en       = 1'b0;
    rec_data     = '0;
    rec_pkt_done = 1'b0;
    rec_byte_num = '0;
    ad_data      = '0;
    n_checks     = 0;
    n_errors     = 0;
    fill_table();
    repeat (4) @(posedge sys_clk);
    #1;
    rst_n = 1'b1;
    check_flag("cfg_load", uut.cfg_load, 1'b0);
    check_flag("meas_done", meas_done, 1'b0);
    check_wave("wave_select", uut.wave_select, dds_pkg::WAVE_SINE);
    check_sample("da_data", da_data, 8'h80);  // midscale sine at phase 0
    check_sample("ad_max", ad_max, 8'h00);
    check_sample("ad_min", ad_min, 8'h00);
    check_sample("ad_vpp", ad_vpp, 8'h00);
    for (int i = 0; i < N_ENTRY; i++) begin
      send_packet(tbl[i]);
      check_flag("cfg_load", uut.cfg_load, tbl[i].exp_load);
      check_wave("wave_select", uut.wave_select, tbl[i].exp_wave);
      check_dac(tbl[i]);
      measure_windows(tbl[i]);
    end
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
dds_pkg.sv
dds_cmd_regs.sv
dds_phase_acc.sv
dds_wave_gen.sv
adc_measure.sv
dds_dso_top.sv
tb_clk_gen.sv
dds_dso_props.sv
tb_dds_dso_top.sv

// ==== Makefile ====
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_dds_dso_top
FILELIST   = files.f
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = TEST RESULT: FAIL

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
